// File: Makefile
TOP = tb_audio_loop

.PHONY: lint sim clean

lint:
	verilator --lint-only --top-module audio_loop_top \
		rtl/board_pkg.sv rtl/audio_pkg.sv rtl/i2s_mic_receiver.sv \
		rtl/sample_fifo.sv rtl/i2s_audio_out.sv rtl/audio_loop_top.sv

sim:
	verilator --binary --assert --timing -Wno-fatal --top-module $(TOP) -f build.f
	obj_dir/V$(TOP) +verilator+error+limit+100 | tee /dev/stderr | \
		grep -q "All checks passed"

clean:
	rm -rf obj_dir

// File: build.f
rtl/board_pkg.sv
rtl/audio_pkg.sv
rtl/i2s_mic_receiver.sv
rtl/sample_fifo.sv
rtl/i2s_audio_out.sv
rtl/audio_loop_top.sv
sim/sample_fifo_assertions.sv
sim/tb_audio_loop.sv

// File: rtl/audio_loop_top.sv
`timescale 1ns/1ps

module audio_loop_top
#(
    parameter clk_mhz    = board_pkg::clk_mhz_default,
              sck_div    = clk_mhz / 12,            // About 6 MHz bit clock at 50 MHz
              fifo_depth = audio_pkg::fifo_depth_default
)
(
    input                                clk,
    input                                rst,
    input                                play,       // Lab switch, low pauses
    input                                mic_sd,
    output                               mic_sck,
    output                               mic_ws,
    output                               dac_bclk,
    output                               dac_lrclk,
    output                               dac_sdata,
    output logic [board_pkg::w_led - 1:0] led
);

    import board_pkg::*;
    import audio_pkg::*;

    localparam w_level = $clog2(fifo_depth + 1);

    // ------------------------------
    // Producer

    logic [w_mic_sample - 1:0] mic_sample;
    logic                      mic_valid;

    i2s_mic_receiver
    #(
        .sck_div    ( sck_div    )
    )
    i_mic_receiver
    (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .mic_sd     ( mic_sd     ),
        .mic_sck    ( mic_sck    ),
        .mic_ws     ( mic_ws     ),
        .mic_sample ( mic_sample ),
        .mic_valid  ( mic_valid  )
    );

    // ------------------------------
    // Sample buffer

    logic [w_mic_sample - 1:0] rd_sample;
    logic                      empty;
    logic [w_level - 1:0]      level;
    logic                      overflow;
    logic                      pop;

    sample_fifo
    #(
        .fifo_depth ( fifo_depth )
    )
    i_sample_fifo
    (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .wr         ( mic_valid  ),
        .wr_sample  ( mic_sample ),
        .pop        ( pop        ),
        .rd_sample  ( rd_sample  ),
        .empty      ( empty      ),
        .level      ( level      ),
        .overflow   ( overflow   )
    );

    // ------------------------------
    // Consumer

    i2s_audio_out
    #(
        .sck_div    ( sck_div    )                  // Same frame rate as the mic
    )
    i_audio_out
    (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .play       ( play       ),
        .empty      ( empty      ),
        .rd_sample  ( rd_sample  ),
        .pop        ( pop        ),
        .dac_bclk   ( dac_bclk   ),
        .dac_lrclk  ( dac_lrclk  ),
        .dac_sdata  ( dac_sdata  )
    );

    // ------------------------------
    // LEDs, registered against glitches

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            led <= '0;
        else
            led <= {overflow, (w_led - 1)'(level)};  // Top bit overflow, rest level
    end

endmodule

// File: rtl/audio_pkg.sv
package audio_pkg;

    // ------------------------------
    // Sample formats

    localparam w_mic_sample = 24;           // INMP441-style mic word
    localparam w_dac_sample = 16;           // DAC word, top bits of mic word

    // ------------------------------
    // I2S frame layout

    // Bit clocks per channel slot; a frame is two slots,
    // left slot while word select is low
    localparam slot_bits    = 32;

    // Data starts one bit clock after the word select edge,
    // MSB first, changes on falling bit clock, sampled on rising

    // ------------------------------
    // Sample buffer

    localparam fifo_depth_default = 8;      // Power of two, at least 2

    // The level width follows from the depth, see sample_fifo

endpackage

// File: rtl/board_pkg.sv
package board_pkg;

    // ------------------------------
    // Lab board clocking

    // Main oscillator on the board, in MHz
    localparam clk_mhz_default = 50;

    // ------------------------------
    // Onboard indicators

    // Green LED bank
    //   bit 7     sticky overflow of the sample buffer
    //   low bits  sample buffer level
    localparam w_led = 8;

    // Position of the overflow flag in the LED word
    // is always the top bit, whatever the width

endpackage

// File: rtl/i2s_audio_out.sv
`timescale 1ns/1ps

module i2s_audio_out
#(
    parameter sck_div = 4                           // clk cycles per half bit clock
)
(
    input                                  clk,
    input                                  rst,
    input                                  play,       // Low pauses playback
    input                                  empty,      // Buffer has no word
    input  [audio_pkg::w_mic_sample - 1:0] rd_sample,  // Buffer head word
    output                                 pop,        // One clk at frame start
    output logic                           dac_bclk,
    output                                 dac_lrclk,  // Low = left slot
    output logic                           dac_sdata
);

    import audio_pkg::*;

    localparam w_div  = sck_div > 1 ? $clog2(sck_div) : 1;
    localparam w_slot = $clog2(2 * slot_bits);

    // ------------------------------
    // Bit clock divider

    logic [w_div - 1:0] div_cnt;
    logic               half_tick;
    logic               sck_fall;                   // Data and lrclk move here

    assign half_tick = (div_cnt == w_div'(sck_div - 1));
    assign sck_fall  = half_tick & dac_bclk;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt  <= '0;
            dac_bclk <= 1'b0;
        end
        else if (half_tick)
        begin
            div_cnt  <= '0;
            dac_bclk <= ~dac_bclk;
        end
        else
            div_cnt <= div_cnt + 1'b1;
    end

    // ------------------------------
    // Slot counter, frame and slot starts

    logic [w_slot - 1:0] bit_cnt;
    logic [w_slot - 1:0] nxt_cnt;                   // Position after this fall
    logic                frame_start;
    logic                slot_start;                // MSB goes out

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            bit_cnt <= '0;
        else if (sck_fall)
            bit_cnt <= nxt_cnt;
    end

    assign nxt_cnt     = bit_cnt + 1'b1;
    assign dac_lrclk   = bit_cnt[w_slot - 1];
    assign frame_start = sck_fall & (nxt_cnt == '0);             // lrclk falls
    assign slot_start  = sck_fall & (nxt_cnt[w_slot - 2:0] == 1'b1);  // One bit after edge

    // ------------------------------
    // Frame word, popped at frame start

    logic                      take;                // Buffer word is used
    logic [w_dac_sample - 1:0] hold;                // Word for both slots

    assign take = play & ~empty;
    assign pop  = frame_start & take;               // Head is latched on this clk

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            hold <= '0;                             // First frame is silent
        else if (frame_start)
            hold <= take ? rd_sample[w_mic_sample - 1 -: w_dac_sample] : '0;
    end

    // ------------------------------
    // Serializer

    logic [w_dac_sample - 1:0] shift;

    always_ff @(posedge clk)
    begin
        if (slot_start)
            shift <= {hold[w_dac_sample - 2:0], 1'b0};   // MSB already on the pin
        else if (sck_fall)
            shift <= {shift[w_dac_sample - 2:0], 1'b0};  // Zeros fill the slot tail
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            dac_sdata <= 1'b0;
        else if (slot_start)
            dac_sdata <= hold[w_dac_sample - 1];
        else if (sck_fall)
            dac_sdata <= shift[w_dac_sample - 1];
    end

endmodule

// File: rtl/i2s_mic_receiver.sv
`timescale 1ns/1ps

module i2s_mic_receiver
#(
    parameter sck_div = 4                           // clk cycles per half bit clock
)
(
    input                                        clk,
    input                                        rst,
    input                                        mic_sd,      // Serial data from mic
    output logic                                 mic_sck,     // Bit clock to mic
    output                                       mic_ws,      // Word select, low = left
    output logic [audio_pkg::w_mic_sample - 1:0] mic_sample,  // Last left word
    output logic                                 mic_valid    // One clk strobe per frame
);

    import audio_pkg::*;

    localparam w_div  = sck_div > 1 ? $clog2(sck_div) : 1;
    localparam w_slot = $clog2(2 * slot_bits);      // 6 bits for a 64-bit frame

    // ------------------------------
    // Bit clock divider

    logic [w_div - 1:0] div_cnt;
    logic               half_tick;                  // Bit clock toggles on this clk
    logic               sck_rise;
    logic               sck_fall;

    assign half_tick = (div_cnt == w_div'(sck_div - 1));
    assign sck_rise  = half_tick & ~mic_sck;        // sck goes 0 -> 1
    assign sck_fall  = half_tick &  mic_sck;        // sck goes 1 -> 0

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt <= '0;
            mic_sck <= 1'b0;
        end
        else if (half_tick)
        begin
            div_cnt <= '0;
            mic_sck <= ~mic_sck;
        end
        else
            div_cnt <= div_cnt + 1'b1;
    end

    // ------------------------------
    // Slot counter, word select

    logic [w_slot - 1:0] bit_cnt;                   // Bit position in frame

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            bit_cnt <= '0;                          // As if ws just fell
        else if (sck_fall)
            bit_cnt <= bit_cnt + 1'b1;              // Moves with the data
    end

    assign mic_ws = bit_cnt[w_slot - 1];            // Upper half of frame is right

    // ------------------------------
    // Left word capture

    logic [w_mic_sample - 1:0] shift;
    logic                      capture;
    logic                      last_bit;

    // Position 0 still holds the previous LSB, left bits are 1 .. 24
    assign capture  = sck_rise & (bit_cnt != '0)
                    & (bit_cnt <= w_slot'(w_mic_sample));
    assign last_bit = sck_rise & (bit_cnt == w_slot'(w_mic_sample));

    always_ff @(posedge clk)
    begin
        if (capture)
            shift <= {shift[w_mic_sample - 2:0], mic_sd};   // MSB first
    end

    always_ff @(posedge clk)
    begin
        if (last_bit)
            mic_sample <= {shift[w_mic_sample - 2:0], mic_sd};  // Full word
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            mic_valid <= 1'b0;
        else
            mic_valid <= last_bit;                  // Word is stable with the strobe
    end

endmodule

// File: rtl/sample_fifo.sv
`timescale 1ns/1ps

module sample_fifo
#(
    parameter fifo_depth = 8                        // Power of two, at least 2
)
(
    input                                        clk,
    input                                        rst,
    input                                        wr,          // Write strobe
    input        [audio_pkg::w_mic_sample - 1:0] wr_sample,
    input                                        pop,         // Read strobe
    output       [audio_pkg::w_mic_sample - 1:0] rd_sample,   // Head word, shown ahead
    output                                       empty,
    output logic [$clog2(fifo_depth + 1) - 1:0]  level,       // 0 .. fifo_depth
    output logic                                 overflow     // Sticky
);

    import audio_pkg::*;

    localparam w_ptr   = $clog2(fifo_depth);
    localparam w_level = $clog2(fifo_depth + 1);

    // ------------------------------
    // Storage and pointers

    logic [w_mic_sample - 1:0] mem [fifo_depth];
    logic [w_ptr - 1:0]        wr_ptr;
    logic [w_ptr - 1:0]        rd_ptr;

    logic full;
    logic wr_en;                                    // Write that is kept
    logic rd_en;                                    // Pop that is honoured

    assign full  = (level == w_level'(fifo_depth));
    assign empty = (level == '0);
    assign wr_en = wr  & ~full;                     // Full buffer drops the word
    assign rd_en = pop & ~empty;                    // Pop of empty is ignored

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_ptr] <= wr_sample;
    end

    assign rd_sample = mem[rd_ptr];                 // First word fall through

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;            // Wraps, depth is power of two
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // ------------------------------
    // Occupancy and overflow

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            level <= '0;
        else if (wr_en & ~rd_en)
            level <= level + 1'b1;
        else if (rd_en & ~wr_en)
            level <= level - 1'b1;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            overflow <= 1'b0;
        else if (wr & full)
            overflow <= 1'b1;                       // Held until reset
    end

endmodule

// File: sim/sample_fifo_assertions.sv
`timescale 1ns/1ps

module sample_fifo_assertions
#(
    parameter fifo_depth = 8
)
(
    input                                clk,
    input                                rst,
    input                                pop,
    input                                empty,
    input [$clog2(fifo_depth + 1) - 1:0] level,
    input                                overflow
);

    int fail_count = 0;                             // Failures seen so far

    // ------------------------------
    // Occupancy

    level_in_range: assert property (@(posedge clk) disable iff (rst)
        level <= fifo_depth)
    else
    begin
        $error("Buffer level %0d is above the depth", level);
        fail_count++;
    end

    level_single_step: assert property (@(posedge clk) disable iff (rst)
        (level == $past(level)) || (level == $past(level) + 1'b1)
        || (level == $past(level) - 1'b1))
    else
    begin
        $error("Buffer level jumped by more than one");
        fail_count++;
    end

    // ------------------------------
    // Flags and strobes

    overflow_sticky: assert property (@(posedge clk) disable iff (rst)
        $past(overflow) |-> overflow)
    else
    begin
        $error("Overflow flag fell without reset");
        fail_count++;
    end

    no_pop_when_empty: assert property (@(posedge clk) disable iff (rst)
        !(pop && empty))
    else
    begin
        $error("Pop while the buffer is empty");
        fail_count++;
    end

endmodule

bind sample_fifo sample_fifo_assertions
#(
    .fifo_depth ( fifo_depth )
)
i_sample_fifo_assertions
(
    .clk        ( clk        ),
    .rst        ( rst        ),
    .pop        ( pop        ),
    .empty      ( empty      ),
    .level      ( level      ),
    .overflow   ( overflow   )
);

// File: sim/tb_audio_loop.sv
`timescale 1ns/1ps

module tb_audio_loop;

    import board_pkg::*;
    import audio_pkg::*;

    localparam sck_div      = 4;
    localparam fifo_depth   = fifo_depth_default;
    localparam frame_cycles = 4 * slot_bits * sck_div;  // Two slots, two halves per bit
    localparam wait_limit   = 20 * frame_cycles;
    localparam time t_drive = 10;                       // Input delay after clk rise

    logic               clk    = 1'b0;
    logic               rst    = 1'b1;
    logic               play   = 1'b0;                  // Lab switch
    logic               mic_sd = 1'b0;
    logic               mic_sck;
    logic               mic_ws;
    logic               dac_bclk;
    logic               dac_lrclk;
    logic               dac_sdata;
    logic [w_led - 1:0] led;

    audio_loop_top
    #(
        .clk_mhz    ( clk_mhz_default ),
        .sck_div    ( sck_div         ),
        .fifo_depth ( fifo_depth      )
    )
    i_audio_loop_top ( .* );

    always #50 clk = ~clk;                              // 100 ns period

    integer                    seed = 32'h21c9570f;
    int                        errors;
    int                        test_errors;             // Count at test start
    int                        tests_done;
    int                        tests_failed;
    int                        base_count;
    string                     test_name = "reset";
    logic [w_dac_sample - 1:0] sent_q [$];              // Top bits of each word sent
    int                        rx_count;                // Non-zero frames seen
    bit                        zero_check;              // Paused frames must be silent
    bit                        order_check = 1'b1;
    bit                        timed_out;               // Later waits are skipped

    // ------------------------------
    // Helpers

    task automatic next_cycle();
        @(posedge clk);
        #t_drive;                                       // Outputs settled before inputs move
    endtask

    task automatic expect_equal(input logic [31:0] expected, input logic [31:0] actual,
                                input string what);
        assert (actual == expected)
        else
        begin
            $display("ERROR %s: %s expected %h, actual %h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic report_timeout(input string why);
        $display("Timeout in test %s while waiting for %s", test_name, why);
        timed_out = 1'b1;
        errors++;
    endtask

    task automatic wait_led(input logic [w_led - 1:0] mask, input logic [w_led - 1:0] value,
                            input string why);
        int cycles;
        cycles = 0;
        while (!timed_out && (led & mask) != value && cycles < wait_limit)
        begin
            next_cycle();
            cycles++;
        end
        if (!timed_out && (led & mask) != value)
            report_timeout(why);
    endtask

    task automatic wait_rx(input int target);
        int cycles;
        cycles = 0;
        while (!timed_out && rx_count < target && cycles < wait_limit)
        begin
            next_cycle();
            cycles++;
        end
        if (!timed_out && rx_count < target)
            report_timeout("samples at the DAC");
    endtask

    task automatic check_idle();
        expect_equal(32'd0, 32'({mic_sck, mic_ws, dac_bclk, dac_lrclk, dac_sdata}), "serial");
        expect_equal(32'd0, 32'(led), "led");
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (16)
        begin
            next_cycle();
            check_idle();
        end
        sent_q.delete();                                // Words cut off by reset
        rx_count = 0;
        rst      = 1'b0;
        check_idle();
        next_cycle();
        check_idle();                                   // Divider still counting
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        tests_done++;
        if (errors != test_errors)
            tests_failed++;
        $display("Test %-22s %s", test_name, (errors == test_errors) ? "ok" : "FAILED");
    endtask

    task automatic take_frame(input logic [w_dac_sample - 1:0] left,
                              input logic [w_dac_sample - 1:0] right);
        expect_equal(32'(left), 32'(right), "right channel");
        if (zero_check)
            expect_equal(32'd0, 32'(left), "paused frame");
        if (left != '0)
        begin
            if (order_check)
            begin
                assert (rx_count < sent_q.size())
                else
                begin
                    $display("ERROR %s: the DAC sent a word the mic never sent", test_name);
                    errors++;
                end
                if (rx_count < sent_q.size())
                    expect_equal(32'(sent_q[rx_count]), 32'(left), "sample order");
            end
            rx_count++;
        end
    endtask

    // ------------------------------
    // Microphone model

    logic [w_mic_sample - 1:0] mic_shift;
    int                        mic_pos;                 // Bit clocks since ws fell
    logic                      mic_sck_q;
    logic                      mic_ws_q;

    always @(posedge clk)
    begin
        #t_drive;
        if (rst)
        begin
            mic_pos   = 99;                             // Silent until ws falls
            mic_sck_q = 1'b0;
            mic_ws_q  = 1'b0;
            mic_sd    = 1'b0;
        end
        else
        begin
            if (mic_sck_q && !mic_sck)                  // Falling bit clock
            begin
                mic_pos++;
                if (mic_ws_q && !mic_ws)                // Left slot starts
                begin
                    mic_pos   = 0;
                    mic_shift = 24'($random(seed));
                    if (mic_shift[w_mic_sample - 1 -: w_dac_sample] == '0)
                        mic_shift[w_mic_sample - 1] = 1'b1;     // Zero means silence
                    sent_q.push_back(mic_shift[w_mic_sample - 1 -: w_dac_sample]);
                end
                mic_sd = 1'b0;
                if (mic_pos >= 1 && mic_pos <= w_mic_sample)
                begin
                    mic_sd    = mic_shift[w_mic_sample - 1];    // MSB first
                    mic_shift = mic_shift << 1;
                end
            end
            mic_sck_q = mic_sck;
            mic_ws_q  = mic_ws;
        end
    end

    // ------------------------------
    // DAC sink

    logic [w_dac_sample - 1:0] rx_shift;
    logic [w_dac_sample - 1:0] rx_left;
    int                        rx_pos;                  // Bit position in slot
    logic                      bclk_q;
    logic                      lr_q;

    always @(posedge clk)
    begin
        #t_drive;
        if (rst)
        begin
            rx_pos = -1;                                // Reset acts as a left edge
            bclk_q = 1'b0;
            lr_q   = 1'b0;
        end
        else
        begin
            if (!bclk_q && dac_bclk)                    // Rising bit clock
            begin
                rx_pos = (dac_lrclk != lr_q) ? 0 : rx_pos + 1;
                lr_q   = dac_lrclk;
                if (rx_pos >= 1 && rx_pos <= w_dac_sample)
                    rx_shift = {rx_shift[w_dac_sample - 2:0], dac_sdata};
                if (rx_pos == w_dac_sample && !dac_lrclk)
                    rx_left = rx_shift;
                else if (rx_pos == w_dac_sample)
                    take_frame(rx_left, rx_shift);      // Right slot ends the frame
            end
            bclk_q = dac_bclk;
        end
    end

    // ------------------------------
    // Test sequence

    initial
    begin
        start_test("reset");
        apply_reset();
        end_test();

        start_test("loopback");
        play = 1'b1;
        wait_rx(6);
        end_test();

        start_test("pause");
        play = 1'b0;
        wait_led(8'h7f, 8'd2, "buffer to fill");        // Last played frame is over
        zero_check = 1'b1;
        wait_led(8'h7f, 8'(fifo_depth), "full buffer");
        expect_equal(32'd0, 32'(led[w_led - 1]), "overflow flag");
        end_test();

        start_test("overflow");
        wait_led(8'h80, 8'h80, "overflow flag");
        zero_check = 1'b0;
        base_count = rx_count;
        play       = 1'b1;
        wait_rx(base_count + fifo_depth);               // Buffer contents in order
        order_check = 1'b0;                             // Later words were dropped
        end_test();

        start_test("reset clears overflow");
        apply_reset();
        order_check = 1'b1;
        wait_rx(6);
        end_test();

        errors += i_audio_loop_top.i_sample_fifo.i_sample_fifo_assertions.fail_count;
        $display("%0d tests, %0d failed, %0d errors", tests_done, tests_failed, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule
